// File: ifu_macros.svh
/*
 * sizing values for the instruction fetch front end
 * the memory depth must match the 8-bit address range
 * the credit count is the depth of the consumer's record buffer
 */
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// bytes of program and data storage
`define IFU_MEM_DEPTH 256

// records the consumer can take before it returns a credit
`define IFU_CREDITS 4

// pc loaded on reset, fetch still waits for a redirect
`define IFU_RESET_PC 8'h00

`endif

// File: isa_pkg.sv
/*
 * instruction set types for the byte-coded CPU front end
 * only the first opcode page is covered, so opcodes are 8 bits
 * lengths count the opcode byte plus all operand bytes
 */
`default_nettype none

package isa_pkg;

	// ==================================================
	// opcodes
	// ==================================================
	// values not listed here are still legal on the bus and decode as length 0
	typedef enum logic [7:0] {
		BRK       = 8'h00,
		CLC       = 8'h18,
		JSR       = 8'h20,
		JMP       = 8'h4C,
		RTS       = 8'h60,
		ADD_IMM8  = 8'h65,
		ADD_IMM32 = 8'h69,
		BRA       = 8'h80,
		BRL       = 8'h82,
		ST_ABSX   = 8'h9D,
		LDA_IMM8  = 8'hA9,
		LDA_ABS   = 8'hAD,
		LDA_ABSX  = 8'hBD,
		NOP       = 8'hEA
	} opcode_t;

	// ==================================================
	// widths
	// ==================================================
	// the longest instruction is 7 bytes so 4 bits leave room
	typedef logic [3:0] inst_len_t;

	// the pc spans the whole byte memory
	typedef logic [7:0] pc_t;

endpackage

`default_nettype wire

// File: bus_pkg.sv
/*
 * memory bus types shared by the arbiter and the fetch unit
 * the bus carries one byte per access, there are no byte enables
 */
`default_nettype none

package bus_pkg;

	// one address per byte of storage
	typedef logic [7:0] addr_t;

	typedef logic [7:0] byte_t;

	// requesters on the shared memory port
	typedef enum logic {
		REQ_FETCH = 1'b0,
		REQ_DATA  = 1'b1
	} req_id_t;

	// fetch sequencer states
	// IDLE and HALT both wait for a redirect, IDLE is only left by the first one
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		REQ  = 3'd1,
		WAIT = 3'd2,
		EMIT = 3'd3,
		HALT = 3'd4
	} fetch_state_t;

endpackage

`default_nettype wire

// File: inst_len_decode.sv
/*
 * opcode to instruction length table, purely combinational
 * a length of 0 marks a control transfer or an unknown opcode
 * and stops sequential fetch, suppress forces 0 for every opcode
 */
`timescale 1ns/1ps
`default_nettype none

module inst_len_decode (
	input  wire isa_pkg::opcode_t  opcode,
	input  wire logic              suppress,
	output isa_pkg::inst_len_t     len
);

	// the table is small enough to map to a handful of LUTs
	always_comb begin
		if (suppress) begin
			// pending interrupt, the pc must not run on past this opcode
			len = 4'd0;
		end else begin
			case (opcode)
				// break and all control transfers leave the pc to someone else
				isa_pkg::BRK,
				isa_pkg::JSR,
				isa_pkg::JMP,
				isa_pkg::RTS: len = 4'd0;

				// single byte instructions
				isa_pkg::CLC,
				isa_pkg::NOP: len = 4'd1;

				// short branch and 8-bit immediate load carry one operand byte
				isa_pkg::BRA,
				isa_pkg::LDA_IMM8: len = 4'd2;

				// long branch has a 16-bit displacement
				isa_pkg::BRL,
				isa_pkg::ADD_IMM8: len = 4'd3;

				isa_pkg::LDA_ABS: len = 4'd5;

				// 32-bit immediate and indexed absolute forms
				isa_pkg::ADD_IMM32,
				isa_pkg::LDA_ABSX: len = 4'd6;

				// store indexed carries a register byte on top of the address
				isa_pkg::ST_ABSX: len = 4'd7;

				// unimplemented opcode, treat it as a halt point
				default: len = 4'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: byte_mem.sv
/*
 * single port byte memory with a registered read
 * read data appears one cycle after en, contents are not cleared on reset
 */
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module byte_mem (
	input  wire logic            clk,
	input  wire logic            en,
	input  wire logic            we,
	input  wire bus_pkg::addr_t  addr,
	input  wire bus_pkg::byte_t  wdata,
	output bus_pkg::byte_t       rdata
);

	bus_pkg::byte_t mem [0:`IFU_MEM_DEPTH-1];

	// a write cycle leaves rdata holding the previous read
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
/*
 * round-robin arbiter for the fetch unit and the data port on one byte memory
 * a grant is combinational and takes the memory in the same cycle
 * read data returns one cycle after the grant to the requester that won
 */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            dport_req,
	input  wire logic            dport_we,
	input  wire bus_pkg::addr_t  dport_addr,
	input  wire bus_pkg::byte_t  dport_wdata,
	output logic                 dport_gnt,
	output logic                 dport_rvalid,
	output bus_pkg::byte_t       dport_rdata,
	input  wire logic            fetch_req,
	input  wire bus_pkg::addr_t  fetch_addr,
	output logic                 fetch_gnt,
	output logic                 fetch_rvalid,
	output bus_pkg::byte_t       fetch_rdata
);

	bus_pkg::req_id_t  winner;
	bus_pkg::req_id_t  last_q;
	bus_pkg::req_id_t  owner_q;
	logic              any_req;
	logic              rd_q;
	logic              mem_en;
	logic              mem_we;
	bus_pkg::addr_t    mem_addr;
	bus_pkg::byte_t    mem_wdata;
	bus_pkg::byte_t    mem_rdata;

	// ==================================================
	// grant selection
	// ==================================================
	assign any_req = fetch_req | dport_req;

	// on a tie the requester that lost last time goes first
	always_comb begin
		if (fetch_req && dport_req) begin
			winner = (last_q == bus_pkg::REQ_FETCH) ? bus_pkg::REQ_DATA : bus_pkg::REQ_FETCH;
		end else if (dport_req) begin
			winner = bus_pkg::REQ_DATA;
		end else begin
			winner = bus_pkg::REQ_FETCH;
		end
	end

	assign fetch_gnt = any_req && (winner == bus_pkg::REQ_FETCH);
	assign dport_gnt = any_req && (winner == bus_pkg::REQ_DATA);

	// fetch never writes, so only the data port can raise we
	assign mem_en    = any_req;
	assign mem_we    = dport_gnt & dport_we;
	assign mem_addr  = (winner == bus_pkg::REQ_DATA) ? dport_addr : fetch_addr;
	assign mem_wdata = dport_wdata;

	// ==================================================
	// read return
	// ==================================================
	// last_q starts on the data port so the first tie goes to fetch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_q  <= bus_pkg::REQ_DATA;
			owner_q <= bus_pkg::REQ_FETCH;
			rd_q    <= 1'b0;
		end else begin
			rd_q <= mem_en & ~mem_we;
			if (any_req) begin
				last_q  <= winner;
				owner_q <= winner;
			end
		end
	end

	// both requesters see the memory output, rvalid tells them whose it is
	assign fetch_rvalid = rd_q && (owner_q == bus_pkg::REQ_FETCH);
	assign dport_rvalid = rd_q && (owner_q == bus_pkg::REQ_DATA);
	assign fetch_rdata  = mem_rdata;
	assign dport_rdata  = mem_rdata;

	byte_mem u_mem (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// File: fetch_unit.sv
/*
 * fetch sequencer, one opcode byte per instruction
 * operand bytes are skipped by the decoded length and never read
 * a record needs a credit and a length of 0 halts until the next redirect
 */
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module fetch_unit (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                redirect_valid,
	input  wire isa_pkg::pc_t        redirect_pc,
	input  wire logic                irq,
	output logic                     fetch_req,
	output bus_pkg::addr_t           fetch_addr,
	input  wire logic                fetch_gnt,
	input  wire logic                fetch_rvalid,
	input  wire bus_pkg::byte_t      fetch_rdata,
	input  wire logic                credit_return,
	output logic                     inst_valid,
	output isa_pkg::pc_t             inst_pc,
	output isa_pkg::opcode_t         inst_opcode,
	output isa_pkg::inst_len_t       inst_len,
	output logic                     halted
);

	// wide enough to hold the full credit count
	localparam int CW = $clog2(`IFU_CREDITS + 1);

	bus_pkg::fetch_state_t  state_q;
	isa_pkg::pc_t           pc_q;
	isa_pkg::opcode_t       opcode_q;
	isa_pkg::inst_len_t     dec_len;
	logic [CW-1:0]          credit_q;
	logic                   irq_q;
	logic                   emit;

	// the length is decoded at emit time so a late irq still suppresses it
	inst_len_decode u_dec (
		.opcode   (opcode_q),
		.suppress (irq_q),
		.len      (dec_len)
	);

	// a record goes out only from EMIT with a credit in hand
	assign emit = (state_q == bus_pkg::EMIT) && (credit_q != '0);

	assign fetch_req  = (state_q == bus_pkg::REQ);
	assign fetch_addr = bus_pkg::addr_t'(pc_q);
	assign halted     = (state_q == bus_pkg::HALT) || (state_q == bus_pkg::IDLE);

	// ==================================================
	// sequencer
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= bus_pkg::IDLE;
			pc_q    <= `IFU_RESET_PC;
			irq_q   <= 1'b0;
		end else begin
			irq_q <= irq;
			if (redirect_valid) begin
				// a redirect drops whatever record is in flight
				pc_q    <= redirect_pc;
				state_q <= bus_pkg::REQ;
			end else begin
				case (state_q)
					bus_pkg::REQ: if (fetch_gnt) state_q <= bus_pkg::WAIT;
					bus_pkg::WAIT: if (fetch_rvalid) state_q <= bus_pkg::EMIT;
					bus_pkg::EMIT: begin
						if (emit) begin
							pc_q    <= pc_q + isa_pkg::pc_t'(dec_len);
							state_q <= (dec_len == '0) ? bus_pkg::HALT : bus_pkg::REQ;
						end
					end
					// IDLE and HALT wait for a redirect
					default: state_q <= state_q;
				endcase
			end
		end
	end

	// opcode byte is captured as it comes back from the memory
	always_ff @(posedge clk) begin
		if (state_q == bus_pkg::WAIT && fetch_rvalid) begin
			opcode_q <= isa_pkg::opcode_t'(fetch_rdata);
		end
	end

	// ==================================================
	// credits and record output
	// ==================================================
	// a return and a spend in the same cycle cancel out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_q   <= CW'(`IFU_CREDITS);
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= emit;
			if (credit_return && !emit) begin
				credit_q <= credit_q + 1'b1;
			end else if (emit && !credit_return) begin
				credit_q <= credit_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			inst_pc     <= pc_q;
			inst_opcode <= opcode_q;
			inst_len    <= dec_len;
		end
	end

endmodule

`default_nettype wire

// File: ifu_top.sv
/*
 * instruction fetch front end, the data port shares memory with fetch
 * nothing runs until the first redirect after reset
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                dport_req,
	input  wire logic                dport_we,
	input  wire bus_pkg::addr_t      dport_addr,
	input  wire bus_pkg::byte_t      dport_wdata,
	output logic                     dport_gnt,
	output logic                     dport_rvalid,
	output bus_pkg::byte_t           dport_rdata,
	input  wire logic                redirect_valid,
	input  wire isa_pkg::pc_t        redirect_pc,
	input  wire logic                irq,
	input  wire logic                credit_return,
	output logic                     inst_valid,
	output isa_pkg::pc_t             inst_pc,
	output isa_pkg::opcode_t         inst_opcode,
	output isa_pkg::inst_len_t       inst_len,
	output logic                     halted
);

	// fetch side of the shared memory port
	logic            fetch_req;
	bus_pkg::addr_t  fetch_addr;
	logic            fetch_gnt;
	logic            fetch_rvalid;
	bus_pkg::byte_t  fetch_rdata;

	mem_arbiter u_arb (
		.clk          (clk),
		.rst_n        (rst_n),
		.dport_req    (dport_req),
		.dport_we     (dport_we),
		.dport_addr   (dport_addr),
		.dport_wdata  (dport_wdata),
		.dport_gnt    (dport_gnt),
		.dport_rvalid (dport_rvalid),
		.dport_rdata  (dport_rdata),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.fetch_gnt    (fetch_gnt),
		.fetch_rvalid (fetch_rvalid),
		.fetch_rdata  (fetch_rdata)
	);

	fetch_unit u_fetch (
		.clk            (clk),
		.rst_n          (rst_n),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.irq            (irq),
		.fetch_req      (fetch_req),
		.fetch_addr     (fetch_addr),
		.fetch_gnt      (fetch_gnt),
		.fetch_rvalid   (fetch_rvalid),
		.fetch_rdata    (fetch_rdata),
		.credit_return  (credit_return),
		.inst_valid     (inst_valid),
		.inst_pc        (inst_pc),
		.inst_opcode    (inst_opcode),
		.inst_len       (inst_len),
		.halted         (halted)
	);

endmodule

`default_nettype wire

// File: tb_ifu.sv
/*
 * testbench for the instruction fetch front end
 * the program is loaded over the data port, then the record stream is checked
 * against a table, under back-pressure, irq and data-port contention
 * program and filler only use addresses below 0x50
 */
`timescale 1ns/1ps
`default_nettype none

`include "ifu_macros.svh"

module tb_ifu;

	logic                clk;
	logic                rst_n;
	logic                dport_req;
	logic                dport_we;
	bus_pkg::addr_t      dport_addr;
	bus_pkg::byte_t      dport_wdata;
	logic                dport_gnt;
	logic                dport_rvalid;
	bus_pkg::byte_t      dport_rdata;
	logic                redirect_valid;
	isa_pkg::pc_t        redirect_pc;
	logic                irq;
	logic                credit_return = 1'b0;
	logic                inst_valid;
	isa_pkg::pc_t        inst_pc;
	isa_pkg::opcode_t    inst_opcode;
	isa_pkg::inst_len_t  inst_len;
	logic                halted;

	// opcode bytes as {addr, opcode}, every other byte below 0x50 is operand filler
	logic [15:0] prog_tab [0:17] = '{
		16'h00A9, 16'h0218, 16'h0365, 16'h06AD, 16'h0BEA, 16'h0C69, 16'h12BD, 16'h189D,
		16'h1F80, 16'h2182, 16'h244C, 16'h30EA, 16'h3177, 16'h3818, 16'h3900, 16'h40EA,
		16'h4420, 16'h4660
	};

	// expected records as hex digits {pc, opcode, len}
	// 0..10 is the main run up to JMP, 11..12 ends on an unknown opcode,
	// 13..14 ends on BRK, 15 is the NOP that an irq cuts to length 0
	// 16 and 17 are JSR and RTS, each one a halt point by itself
	logic [19:0] exp_tab [0:17] = '{
		20'h00A92, 20'h02181, 20'h03653, 20'h06AD5, 20'h0BEA1, 20'h0C696, 20'h12BD6,
		20'h189D7, 20'h1F802, 20'h21823, 20'h244C0, 20'h30EA1, 20'h31770, 20'h38181,
		20'h39000, 20'h40EA0, 20'h44200, 20'h46600
	};

	// image of what the memory should hold after the load
	bus_pkg::byte_t img [0:255];

	integer       seed = 32'ha446;
	logic [31:0]  rnd = '0;
	logic         credit_auto = 1'b0;
	int           rec_count = 0;
	int           ret_count = 0;
	int           exp_base = 0;
	int           exp_end = 0;
	int           cnt_base = 0;
	int           mon_idx;

	ifu_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==================================================
	// failure reporting
	// ==================================================
	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "stopped on the first failure");
	endtask

	task automatic report_mismatch(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	task automatic timeout_abort(input string what);
		$display("Timeout while waiting for %s", what);
		stop_run();
	endtask

	// filler differs in every address bit so a wrong address shows up on readback
	function automatic bus_pkg::byte_t fill_byte(input bus_pkg::addr_t a);
		return {a[3:0], a[7:4]} ^ 8'h3C;
	endfunction

	// ==================================================
	// bus and control tasks
	// ==================================================
	// request is held until grant, read data is due one cycle after the grant
	task automatic dport_access(input logic we, input bus_pkg::addr_t addr,
			input bus_pkg::byte_t wdata, output bus_pkg::byte_t rdata);
		int t;
		t = 0;
		rdata = 8'h00;
		@(posedge clk);
		dport_req   <= 1'b1;
		dport_we    <= we;
		dport_addr  <= addr;
		dport_wdata <= wdata;
		@(negedge clk);
		while (!dport_gnt) begin
			t++;
			if (t > 50) timeout_abort("a data port grant");
			@(negedge clk);
		end
		// the memory takes the access on this edge
		@(posedge clk);
		dport_req <= 1'b0;
		dport_we  <= 1'b0;
		if (!we) begin
			@(negedge clk);
			assert (dport_rvalid) else report_mismatch("no read data one cycle after grant");
			rdata = dport_rdata;
		end
	endtask

	task automatic redirect_to(input isa_pkg::pc_t pc);
		@(posedge clk);
		redirect_valid <= 1'b1;
		redirect_pc    <= pc;
		@(posedge clk);
		redirect_valid <= 1'b0;
	endtask

	// arm the monitor for a slice of the table and start fetch at its first pc
	task automatic start_segment(input int base, input int count);
		exp_base = base;
		exp_end  = base + count;
		cnt_base = rec_count;
		redirect_to(exp_tab[base][19:12]);
	endtask

	task automatic wait_records(input int target);
		int t;
		t = 0;
		while (rec_count < target) begin
			t++;
			if (t > 600) timeout_abort("instruction records");
			@(negedge clk);
		end
	endtask

	task automatic wait_halted();
		int t;
		t = 0;
		while (!halted) begin
			t++;
			if (t > 50) timeout_abort("the fetch unit to halt");
			@(negedge clk);
		end
	endtask

	// nothing may come out during the window
	task automatic quiet_window(input int cycles);
		int start;
		start = rec_count;
		repeat (cycles) @(negedge clk);
		assert (rec_count == start) else report_mismatch("record arrived in a quiet window");
	endtask

	task automatic finish_segment();
		wait_records(cnt_base + exp_end - exp_base);
		wait_halted();
		quiet_window(20);
	endtask

	// all records seen so far have had their credits returned
	task automatic settle_credits();
		int t;
		t = 0;
		while (ret_count != rec_count) begin
			t++;
			if (t > 200) timeout_abort("credits to return");
			@(negedge clk);
		end
	endtask

	// ==================================================
	// consumer side
	// ==================================================
	// returns a credit for each record already seen, at random cycles
	always @(posedge clk) begin
		rnd = $random(seed);
		if (rst_n && credit_auto && (ret_count != rec_count) && (rnd[1:0] != 2'b00)) begin
			credit_return <= 1'b1;
			ret_count     <= ret_count + 1;
		end else begin
			credit_return <= 1'b0;
		end
	end

	// record check against the armed slice of the table
	always @(negedge clk) begin
		if (rst_n && inst_valid) begin
			mon_idx = exp_base + (rec_count - cnt_base);
			assert (mon_idx < exp_end)
			else report_mismatch($sformatf("unexpected record at pc %h", inst_pc));
			assert (inst_pc == exp_tab[mon_idx][19:12] &&
					8'(inst_opcode) == exp_tab[mon_idx][11:4] &&
					inst_len == exp_tab[mon_idx][3:0])
			else report_mismatch($sformatf("record %0d is pc %h op %h len %0d, expected %h",
					mon_idx, inst_pc, 8'(inst_opcode), inst_len, exp_tab[mon_idx]));
			rec_count <= rec_count + 1;
		end
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		bus_pkg::byte_t rd;
		bus_pkg::addr_t addr;
		int n;
		rst_n          = 1'b0;
		dport_req      = 1'b0;
		dport_we       = 1'b0;
		dport_addr     = '0;
		dport_wdata    = '0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		irq            = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (halted && !inst_valid && !dport_gnt && !dport_rvalid)
		else report_mismatch("outputs not at their reset values");

		// program load over the data port, then a full readback
		for (int a = 0; a < 'h50; a++) begin
			img[a] = fill_byte(bus_pkg::addr_t'(a));
		end
		for (int i = 0; i < 18; i++) begin
			img[prog_tab[i][15:8]] = prog_tab[i][7:0];
		end
		for (int a = 0; a < 'h50; a++) begin
			dport_access(1'b1, bus_pkg::addr_t'(a), img[a], rd);
		end
		for (int a = 0; a < 'h50; a++) begin
			dport_access(1'b0, bus_pkg::addr_t'(a), 8'h00, rd);
			assert (rd == img[a])
			else report_mismatch($sformatf("readback at %h gave %h, expected %h", a, rd, img[a]));
		end

		// sequential fetch to JMP, then restarts that halt on an unknown opcode and BRK
		credit_auto = 1'b1;
		start_segment(0, 11);
		finish_segment();
		start_segment(11, 2);
		finish_segment();
		start_segment(13, 2);
		finish_segment();

		// call and return leave the pc to the execute stage
		start_segment(16, 1);
		finish_segment();
		start_segment(17, 1);
		finish_segment();

		// with no credits back only the first IFU_CREDITS records may come out
		settle_credits();
		credit_auto = 1'b0;
		start_segment(0, 11);
		wait_records(cnt_base + `IFU_CREDITS);
		quiet_window(20);
		assert (!halted) else report_mismatch("fetch unit halted while a record was held back");
		credit_auto = 1'b1;
		finish_segment();

		// irq suppresses the length of the first record after the redirect
		@(posedge clk);
		irq <= 1'b1;
		start_segment(15, 1);
		finish_segment();
		@(posedge clk);
		irq <= 1'b0;

		// data-port reads at random gaps while fetch runs the main program
		start_segment(0, 11);
		n = 0;
		while (rec_count < cnt_base + 11 && n < 40) begin
			@(negedge clk);
			addr = {2'b00, rnd[9:4]};
			repeat (rnd[2:0]) @(posedge clk);
			dport_access(1'b0, addr, 8'h00, rd);
			assert (rd == img[addr])
			else report_mismatch($sformatf("read at %h under contention gave %h", addr, rd));
			n++;
		end
		finish_segment();

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
isa_pkg.sv
bus_pkg.sv
inst_len_decode.sv
byte_mem.sv
mem_arbiter.sv
fetch_unit.sv
ifu_top.sv
tb_ifu.sv

// File: Makefile
# Verilator build for the instruction fetch front end testbench

VERILATOR ?= verilator
TOP       := tb_ifu
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
SIM       := obj_dir/V$(TOP)
PASS_MSG  := Simulation passed

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the simulator output is shown and then searched for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
